/* sparse_cluster.f */
hdl/sparse_pkg.sv
hdl/ifm_chunk_mem.sv
hdl/ifm_read_arbiter.sv
hdl/compute_unit.sv
hdl/compute_cluster.sv
verification/tb_compute_cluster.sv

/* Makefile */
# Verilator build and run of the compute cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_compute_cluster
FILELIST  ?= sparse_cluster.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
RUNFLAGS  ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUNFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_compute_cluster.sv */
`default_nettype none

module tb_compute_cluster;

	localparam int NUM_UNITS = 4;
	localparam int NUM_BUFS = 4;
	localparam int USEL_W = $clog2(NUM_UNITS);
	localparam int BSEL_W = $clog2(NUM_BUFS);
	localparam int CHUNK = sparse_pkg::LANES * sparse_pkg::BEATS;

	// Worst chunk has every beat wait a full round of all units
	localparam int CHUNK_WORST = sparse_pkg::BEATS * NUM_UNITS * 4;
	// Beat loads plus one cycle per checked word, per test step
	localparam int STEP_WORST = (NUM_UNITS + 1) * sparse_pkg::BEATS + NUM_UNITS * NUM_BUFS;
	// Five chunks and about ten steps, doubled
	localparam int MAX_CYCLES = 2 * (5 * CHUNK_WORST + 10 * STEP_WORST);

	logic clk;
	logic rst_n;
	sparse_pkg::beat_wr_t ifm_wr;
	logic ifm_wr_bank;
	logic ifm_rd_bank;
	sparse_pkg::beat_wr_t filter_wr;
	logic [USEL_W-1:0] filter_unit_sel;
	logic init;
	logic chunk_start;
	logic [BSEL_W-1:0] acc_buf_sel;
	logic chunk_end;
	logic [USEL_W-1:0] out_unit_sel;
	logic [BSEL_W-1:0] out_buf_sel;
	sparse_pkg::acc_t out_dat;

	// Dense copies of everything loaded, and the expected buffers
	sparse_pkg::elem_t ifm_dense [2][CHUNK];
	sparse_pkg::elem_t filt_dense [NUM_UNITS][CHUNK];
	sparse_pkg::acc_t exp_acc [NUM_UNITS][NUM_BUFS];

	int seed;
	int cycle_cnt = 0;
	logic chk_word;
	logic chunk_seen;
	sparse_pkg::acc_t exp_word;
	string test_name;

	compute_cluster #(
		 .NUM_UNITS(NUM_UNITS)
		,.NUM_BUFS(NUM_BUFS)
	) UUT (
		 .clk_i(clk)
		,.rst_n_i(rst_n)
		,.ifm_wr_i(ifm_wr)
		,.ifm_wr_bank_i(ifm_wr_bank)
		,.ifm_rd_bank_i(ifm_rd_bank)
		,.filter_wr_i(filter_wr)
		,.filter_unit_sel_i(filter_unit_sel)
		,.init_i(init)
		,.chunk_start_i(chunk_start)
		,.acc_buf_sel_i(acc_buf_sel)
		,.chunk_end_o(chunk_end)
		,.out_unit_sel_i(out_unit_sel)
		,.out_buf_sel_i(out_buf_sel)
		,.out_dat_o(out_dat)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "Timeout after %0d cycles, chunk end never came", cycle_cnt);
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	a_word_value: assert property (
		@(posedge clk) disable iff (!rst_n) chk_word |-> out_dat == exp_word
	) else begin
		$display("error %s unit %0d buf %0d: expected %0d, actual %0d",
			test_name, out_unit_sel, out_buf_sel, exp_word, out_dat);
		$display("*** TEST FAILED ***");
		$fatal(1, "Accumulator word mismatch");
	end

	// No chunk has run yet, so nothing can have ended
	a_end_low_after_reset: assert property (
		@(posedge clk) disable iff (!rst_n) !chunk_seen |-> !chunk_end
	) else begin
		$display("chunk_end_o went high before any chunk was started");
		$display("*** TEST FAILED ***");
		$fatal(1, "Chunk end out of reset");
	end

	a_end_falls: assert property (
		@(posedge clk) disable iff (!rst_n) chunk_start |=> !chunk_end
	) else begin
		$display("chunk_end_o did not fall in the cycle after chunk_start_i");
		$display("*** TEST FAILED ***");
		$fatal(1, "Chunk end did not fall");
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// About half the elements are zero
	function automatic sparse_pkg::elem_t random_elem();
		int r;
		r = $random(seed);
		if (r[0]) begin
			return '0;
		end
		return sparse_pkg::elem_t'(r[15:8]);
	endfunction

	// Nonzero bytes packed from lane 0, junk in the unused slots
	function automatic sparse_pkg::beat_t compress_beat(
		input sparse_pkg::elem_t [sparse_pkg::LANES-1:0] lanes
	);
		sparse_pkg::beat_t bt;
		int pos;
		bt.smap = '0;
		bt.data = {sparse_pkg::LANES{8'hee}};
		pos = 0;
		for (int n = 0; n < sparse_pkg::LANES; n++) begin
			if (lanes[n] != '0) begin
				bt.smap[n] = 1'b1;
				bt.data[pos] = lanes[n];
				pos++;
			end
		end
		return bt;
	endfunction

	function automatic sparse_pkg::acc_t dense_dot(input int u, input int bank);
		sparse_pkg::acc_t sum;
		sum = '0;
		for (int i = 0; i < CHUNK; i++) begin
			sum = sum + sparse_pkg::acc_t'(ifm_dense[bank][i]) * sparse_pkg::acc_t'(filt_dense[u][i]);
		end
		return sum;
	endfunction

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic load_ifm(input int bank);
		sparse_pkg::elem_t [sparse_pkg::LANES-1:0] lanes;
		for (int i = 0; i < CHUNK; i++) begin
			ifm_dense[bank][i] = random_elem();
		end
		for (int b = 0; b < sparse_pkg::BEATS; b++) begin
			for (int n = 0; n < sparse_pkg::LANES; n++) begin
				lanes[n] = ifm_dense[bank][b * sparse_pkg::LANES + n];
			end
			ifm_wr.valid = 1'b1;
			ifm_wr.idx = sparse_pkg::beat_idx_t'(b);
			ifm_wr.beat = compress_beat(lanes);
			ifm_wr_bank = bank[0];
			@(negedge clk);
		end
		ifm_wr = '0;
	endtask

	task automatic load_filter(input int u);
		sparse_pkg::elem_t [sparse_pkg::LANES-1:0] lanes;
		for (int i = 0; i < CHUNK; i++) begin
			filt_dense[u][i] = random_elem();
		end
		for (int b = 0; b < sparse_pkg::BEATS; b++) begin
			for (int n = 0; n < sparse_pkg::LANES; n++) begin
				lanes[n] = filt_dense[u][b * sparse_pkg::LANES + n];
			end
			filter_wr.valid = 1'b1;
			filter_wr.idx = sparse_pkg::beat_idx_t'(b);
			filter_wr.beat = compress_beat(lanes);
			filter_unit_sel = USEL_W'(u);
			@(negedge clk);
		end
		filter_wr = '0;
	endtask

	task automatic start_chunk(input int bank, input int buf_sel);
		ifm_rd_bank = bank[0];
		acc_buf_sel = BSEL_W'(buf_sel);
		chunk_start = 1'b1;
		chunk_seen = 1'b1;
		@(negedge clk);
		chunk_start = 1'b0;
		for (int u = 0; u < NUM_UNITS; u++) begin
			exp_acc[u][buf_sel] = exp_acc[u][buf_sel] + dense_dot(u, bank);
		end
	endtask

	// The cycle counter ends the run if this never returns
	task automatic wait_chunk_end();
		while (!chunk_end) begin
			@(negedge clk);
		end
	endtask

	task automatic check_word(input int u, input int b, input string name);
		out_unit_sel = USEL_W'(u);
		out_buf_sel = BSEL_W'(b);
		exp_word = exp_acc[u][b];
		test_name = name;
		chk_word = 1'b1;
		@(negedge clk);
		chk_word = 1'b0;
	endtask

	task automatic check_all(input string name);
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int b = 0; b < NUM_BUFS; b++) begin
				check_word(u, b, name);
			end
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin : stimulus
		seed = 78414;
		rst_n = 1'b0;
		ifm_wr = '0;
		ifm_wr_bank = 1'b0;
		ifm_rd_bank = 1'b0;
		filter_wr = '0;
		filter_unit_sel = '0;
		init = 1'b0;
		chunk_start = 1'b0;
		acc_buf_sel = '0;
		out_unit_sel = '0;
		out_buf_sel = '0;
		chk_word = 1'b0;
		chunk_seen = 1'b0;
		exp_word = '0;
		test_name = "";
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int b = 0; b < NUM_BUFS; b++) begin
				exp_acc[u][b] = '0;
			end
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_all("reset_zero");

		// All four units contend for the first beat
		for (int u = 0; u < NUM_UNITS; u++) begin
			load_filter(u);
		end
		load_ifm(0);
		start_chunk(0, 0);
		wait_chunk_end();
		check_all("single_chunk");

		load_ifm(0);
		start_chunk(0, 0);
		wait_chunk_end();
		check_all("accumulate");
		load_ifm(0);
		start_chunk(0, 2);
		wait_chunk_end();
		check_all("buffer_select");

		init = 1'b1;
		@(negedge clk);
		init = 1'b0;
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int b = 0; b < NUM_BUFS; b++) begin
				exp_acc[u][b] = '0;
			end
		end
		check_all("init_clear");

		// Bank 1 fills while the units read bank 0
		load_ifm(0);
		start_chunk(0, 1);
		load_ifm(1);
		wait_chunk_end();
		check_all("bank0_during_load");
		start_chunk(1, 3);
		wait_chunk_end();
		check_all("bank1_after_swap");

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/compute_cluster.sv */
`default_nettype none

module compute_cluster #(
	 parameter int NUM_UNITS = 4
	,parameter int NUM_BUFS = 4
)(
	 input wire logic clk_i
	,input wire logic rst_n_i

	,input wire sparse_pkg::beat_wr_t ifm_wr_i
	,input wire logic ifm_wr_bank_i
	,input wire logic ifm_rd_bank_i

	,input wire sparse_pkg::beat_wr_t filter_wr_i
	,input wire logic [((NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1)-1:0] filter_unit_sel_i

	,input wire logic init_i
	,input wire logic chunk_start_i
	,input wire logic [((NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1)-1:0] acc_buf_sel_i
	,output logic chunk_end_o

	,input wire logic [((NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1)-1:0] out_unit_sel_i
	,input wire logic [((NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1)-1:0] out_buf_sel_i
	,output sparse_pkg::acc_t out_dat_o
);

	localparam int USEL_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

	logic [NUM_UNITS-1:0] rd_req;
	logic [NUM_UNITS-1:0] rd_gnt;
	logic [NUM_UNITS-1:0] rd_rsp;
	logic [NUM_UNITS-1:0] done;
	sparse_pkg::beat_idx_t [NUM_UNITS-1:0] rd_idx;
	sparse_pkg::acc_t [NUM_UNITS-1:0] out_dat;

	logic mem_rd_en;
	sparse_pkg::beat_idx_t mem_idx;
	sparse_pkg::beat_t mem_beat;

	//////////////////////////////
	// Shared IFM storage
	//////////////////////////////

	ifm_chunk_mem u_ifm_chunk_mem (
		 .clk_i
		,.rst_n_i
		,.wr_i(ifm_wr_i)
		,.wr_bank_i(ifm_wr_bank_i)
		,.rd_bank_i(ifm_rd_bank_i)
		,.rd_en_i(mem_rd_en)
		,.rd_idx_i(mem_idx)
		,.rd_beat_o(mem_beat)
	);

	ifm_read_arbiter #(
		 .NUM_UNITS(NUM_UNITS)
	) u_ifm_read_arbiter (
		 .clk_i
		,.rst_n_i
		,.req_i(rd_req)
		,.idx_i(rd_idx)
		,.gnt_o(rd_gnt)
		,.rsp_o(rd_rsp)
		,.mem_rd_en_o(mem_rd_en)
		,.mem_idx_o(mem_idx)
	);

	//////////////////////////////
	// Compute units
	//////////////////////////////

	for (genvar u = 0; u < NUM_UNITS; u++) begin : gen_unit
		sparse_pkg::beat_wr_t unit_filter_wr;

		// Filter strobe only reaches the selected unit
		always_comb begin
			unit_filter_wr = filter_wr_i;
			unit_filter_wr.valid = filter_wr_i.valid && (filter_unit_sel_i == USEL_W'(u));
		end

		compute_unit #(
			 .NUM_BUFS(NUM_BUFS)
		) u_compute_unit (
			 .clk_i
			,.rst_n_i
			,.filter_wr_i(unit_filter_wr)
			,.init_i
			,.chunk_start_i
			,.acc_buf_sel_i
			,.rd_req_o(rd_req[u])
			,.rd_idx_o(rd_idx[u])
			,.rd_gnt_i(rd_gnt[u])
			,.rd_rsp_i(rd_rsp[u])
			,.rd_beat_i(mem_beat)
			,.done_o(done[u])
			,.out_buf_sel_i
			,.out_dat_o(out_dat[u])
		);
	end

	assign chunk_end_o = &done;
	assign out_dat_o = out_dat[out_unit_sel_i];

endmodule

`default_nettype wire

/* hdl/compute_unit.sv */
`default_nettype none

module compute_unit #(
	 parameter int NUM_BUFS = 4
)(
	 input wire logic clk_i
	,input wire logic rst_n_i

	,input wire sparse_pkg::beat_wr_t filter_wr_i

	,input wire logic init_i
	,input wire logic chunk_start_i
	,input wire logic [((NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1)-1:0] acc_buf_sel_i

	// IFM read through the arbiter
	,output logic rd_req_o
	,output sparse_pkg::beat_idx_t rd_idx_o
	,input wire logic rd_gnt_i
	,input wire logic rd_rsp_i
	,input wire sparse_pkg::beat_t rd_beat_i

	,output logic done_o

	,input wire logic [((NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1)-1:0] out_buf_sel_i
	,output sparse_pkg::acc_t out_dat_o
);

	localparam int BSEL_W = (NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1;

	typedef enum logic [1:0] {IDLE, REQ, WAIT, ADD} state_t;

	state_t state_q;
	state_t state_d;
	sparse_pkg::beat_idx_t beat_q;
	logic [BSEL_W-1:0] buf_q;
	logic done_q;
	logic last_beat;

	sparse_pkg::beat_t filt_q [sparse_pkg::BEATS];
	sparse_pkg::beat_t ifm_q;
	sparse_pkg::beat_t flt_beat;
	sparse_pkg::smap_t match;
	sparse_pkg::acc_t beat_sum;
	sparse_pkg::acc_t acc_q [NUM_BUFS];

	//////////////////////////////
	// Filter store
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < sparse_pkg::BEATS; i++) begin
				filt_q[i] <= '0;
			end
		end else if (filter_wr_i.valid) begin
			filt_q[filter_wr_i.idx] <= filter_wr_i.beat;
		end
	end

	//////////////////////////////
	// Beat walker FSM
	//////////////////////////////

	assign last_beat = (beat_q == sparse_pkg::beat_idx_t'(sparse_pkg::BEATS-1));

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (chunk_start_i) begin
					state_d = REQ;
				end
			end
			REQ: begin
				if (rd_gnt_i) begin
					state_d = WAIT;
				end
			end
			WAIT: begin
				if (rd_rsp_i) begin
					state_d = ADD;
				end
			end
			ADD: state_d = last_beat ? IDLE : REQ;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			beat_q <= '0;
			buf_q <= '0;
			done_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == IDLE && chunk_start_i) begin
				beat_q <= '0;
				buf_q <= acc_buf_sel_i;
				done_q <= 1'b0;
			end
			if (state_q == ADD) begin
				if (last_beat) begin
					done_q <= 1'b1;
				end else begin
					beat_q <= beat_q + 1'b1;
				end
			end
		end
	end

	assign rd_req_o = (state_q == REQ);
	assign rd_idx_o = beat_q;
	assign done_o = done_q;

	// Returned IFM beat, used in the ADD cycle
	always_ff @(posedge clk_i) begin
		if (state_q == WAIT && rd_rsp_i) begin
			ifm_q <= rd_beat_i;
		end
	end

	//////////////////////////////
	// Sparse match and MAC
	//////////////////////////////

	assign flt_beat = filt_q[beat_q];
	assign match = ifm_q.smap & flt_beat.smap;

	// Running popcounts give each lane's slot in the packed lists
	always_comb begin : mac
		sparse_pkg::lane_idx_t ifm_pos;
		sparse_pkg::lane_idx_t flt_pos;
		sparse_pkg::prod_t prod;
		ifm_pos = '0;
		flt_pos = '0;
		prod = '0;
		beat_sum = '0;
		for (int n = 0; n < sparse_pkg::LANES; n++) begin
			if (match[n]) begin
				prod = ifm_q.data[ifm_pos] * flt_beat.data[flt_pos];
				beat_sum = beat_sum + sparse_pkg::acc_t'(prod);
			end
			ifm_pos = ifm_pos + sparse_pkg::lane_idx_t'(ifm_q.smap[n]);
			flt_pos = flt_pos + sparse_pkg::lane_idx_t'(flt_beat.smap[n]);
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || init_i) begin
			for (int b = 0; b < NUM_BUFS; b++) begin
				acc_q[b] <= '0;
			end
		end else if (state_q == ADD) begin
			acc_q[buf_q] <= acc_q[buf_q] + beat_sum;
		end
	end

	assign out_dat_o = acc_q[out_buf_sel_i];

	a_start_when_idle: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) chunk_start_i |-> state_q == IDLE
	) else $error("Chunk start while the unit is busy");

	// Responses must only come back for this unit's own read
	a_rsp_when_waiting: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) rd_rsp_i |-> state_q == WAIT
	) else $error("Read response without an outstanding read");

endmodule

`default_nettype wire

/* hdl/ifm_read_arbiter.sv */
`default_nettype none

module ifm_read_arbiter #(
	 parameter int NUM_UNITS = 4
)(
	 input wire logic clk_i
	,input wire logic rst_n_i

	// Level requests held until granted
	,input wire logic [NUM_UNITS-1:0] req_i
	,input wire sparse_pkg::beat_idx_t [NUM_UNITS-1:0] idx_i

	,output logic [NUM_UNITS-1:0] gnt_o
	,output logic [NUM_UNITS-1:0] rsp_o

	// Memory read port
	,output logic mem_rd_en_o
	,output sparse_pkg::beat_idx_t mem_idx_o
);

	localparam int SEL_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

	logic [SEL_W-1:0] ptr_q;
	logic [SEL_W-1:0] gnt_sel;
	logic gnt_any;

	//////////////////////////////
	// Round-robin pick
	//////////////////////////////

	// Search starts at the unit after the last one granted
	always_comb begin : pick
		int unsigned cand;
		gnt_o = '0;
		gnt_sel = '0;
		gnt_any = 1'b0;
		for (int k = 0; k < NUM_UNITS; k++) begin
			cand = (int'(ptr_q) + k) % NUM_UNITS;
			if (!gnt_any && req_i[cand]) begin
				gnt_any = 1'b1;
				gnt_sel = SEL_W'(cand);
			end
		end
		if (gnt_any) begin
			gnt_o[gnt_sel] = 1'b1;
		end
	end

	assign mem_rd_en_o = gnt_any;
	assign mem_idx_o = idx_i[gnt_sel];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ptr_q <= '0;
			rsp_o <= '0;
		end else begin
			// Memory data shows up one cycle after the grant
			rsp_o <= gnt_o;
			if (gnt_any) begin
				ptr_q <= (gnt_sel == SEL_W'(NUM_UNITS-1)) ? '0 : gnt_sel + 1'b1;
			end
		end
	end

	// A waiting unit keeps its request and its beat index
	for (genvar u = 0; u < NUM_UNITS; u++) begin : gen_req_chk
		a_req_held: assert property (
			@(posedge clk_i) disable iff (!rst_n_i)
			req_i[u] && !gnt_o[u] |=> req_i[u] && $stable(idx_i[u])
		) else $error("Request or index changed before the grant");
	end

endmodule

`default_nettype wire

/* hdl/ifm_chunk_mem.sv */
`default_nettype none

module ifm_chunk_mem (
	 input wire logic clk_i
	,input wire logic rst_n_i

	// Write side, external loader
	,input wire sparse_pkg::beat_wr_t wr_i
	,input wire logic wr_bank_i

	// Read side, driven through the arbiter
	,input wire logic rd_bank_i
	,input wire logic rd_en_i
	,input wire sparse_pkg::beat_idx_t rd_idx_i
	,output sparse_pkg::beat_t rd_beat_o
);

	// Two banks so the next chunk can load while this one is read
	sparse_pkg::beat_t mem_q [2][sparse_pkg::BEATS];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < sparse_pkg::BEATS; i++) begin
					mem_q[b][i] <= '0;
				end
			end
		end else if (wr_i.valid) begin
			mem_q[wr_bank_i][wr_i.idx] <= wr_i.beat;
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// One cycle latency, only updated on a granted read
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			rd_beat_o <= mem_q[rd_bank_i][rd_idx_i];
		end
	end

	// The bank under computation must stay stable
	a_no_wr_to_rd_bank: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(wr_i.valid && rd_en_i && (wr_bank_i == rd_bank_i))
	) else $error("IFM write hits the bank being read");

endmodule

`default_nettype wire

/* hdl/sparse_pkg.sv */
`default_nettype none

package sparse_pkg;

	//////////////////////////////
	// Chunk geometry
	//////////////////////////////

	// Bytes per beat and beats per chunk, 16 elements in all
	localparam int LANES = 4;
	localparam int BEATS = 4;

	//////////////////////////////
	// Width types
	//////////////////////////////

	typedef logic [7:0] elem_t;
	typedef logic [LANES-1:0] smap_t;
	typedef logic [$clog2(BEATS)-1:0] beat_idx_t;
	// Position inside the packed byte list of one beat
	typedef logic [$clog2(LANES)-1:0] lane_idx_t;
	// Full product of two elements
	typedef logic [15:0] prod_t;
	typedef logic [23:0] acc_t;

	// Sparsemap plus nonzero bytes, lane 0 in the low byte
	typedef struct packed {
		smap_t smap;
		elem_t [LANES-1:0] data;
	} beat_t;

	// One beat write, valid is a single-cycle strobe
	typedef struct packed {
		logic valid;
		beat_idx_t idx;
		beat_t beat;
	} beat_wr_t;

endpackage

`default_nettype wire
